//--- design/ctrl_settings.svh
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

// boot address of the core
// RESET_PC + 4 decodes as the reset marker opcode (inst[6:2] == 1)
`define RESET_PC 32'h4000_0000

// UART register window
// the comment after each address is the mmapSel code it selects
`define UART_CTRL 32'h8000_0000
// 0
`define UART_RX 32'h8000_0004
// 1
`define UART_TX 32'h8000_0008
// 2
`define UART_CC 32'h8000_0010
// 3
`define UART_IC 32'h8000_0014
// 4
`define UART_RST 32'h8000_0018
// 5

// upper address nibbles that hold readable data memory
// written as a value list for use inside an inside {} set
`define DMEM_REGIONS 4'h1, 4'h3, 4'h4

`endif

//--- design/ctrlPkg.sv
package ctrlPkg;

    // opcode field is inst[6:2]
    typedef enum logic [4:0] {
        OP_LOAD   = 5'd0,
        OP_RST    = 5'd1,
        OP_X      = 5'd2,
        OP_I      = 5'd4,
        OP_AUIPC  = 5'd5,
        OP_STORE  = 5'd8,
        OP_R      = 5'd12,
        OP_LUI    = 5'd13,
        OP_BRANCH = 5'd24,
        OP_JALR   = 5'd25,
        OP_JAL    = 5'd27,
        OP_CSRW   = 5'd28
    } opcode_e;

    // encoding is {funct7[5], funct3} for the register ops
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SLL   = 4'd1,
        ALU_SLT   = 4'd2,
        ALU_SLTU  = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SRL   = 4'd5,
        ALU_OR    = 4'd6,
        ALU_AND   = 4'd7,
        ALU_SUB   = 4'd8,
        ALU_PASSB = 4'd9,
        ALU_SRA   = 4'd13
    } aluOp_e;

    typedef enum logic [2:0] {
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5,
        IMM_NONE = 3'd6
    } immFmt_e;

    typedef struct packed {
        logic       readsRs1;
        logic       readsRs2;
        logic       writesRd;
        logic       isCsrw;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
    } regUse_t;

    // execute stage datapath selects
    typedef struct packed {
        logic       aSel;
        logic       bSel;
        aluOp_e     aluSel;
        logic [1:0] pcSel;
        logic       instSel;
        logic [1:0] sSel;
        logic       csrEn;
        logic       csrSel;
        logic       brUn;
        logic       memRW;
        logic [2:0] mmapSel;
    } exCtrl_t;

    // writeback stage selects
    typedef struct packed {
        logic [2:0] ldSel;
        logic [1:0] wbSel;
        logic       regWrEn;
        logic [1:0] mmapDmemSel;
    } wbCtrl_t;

    typedef struct packed {
        logic fa1;
        logic fb1;
        logic fa2;
        logic fb2;
    } fwd_t;

endpackage

//--- design/stageReg.sv
`timescale 1ns/1ps

// one pipeline register, payload type chosen per instance
module stageReg #(
    parameter type T = logic [31:0],
    parameter T RESET_VAL = '0
) (
    input  logic clk,
    input  logic rst,
    input  T     d,
    output T     q
);

    always_ff @(posedge clk) begin
        if (rst) begin
            q <= RESET_VAL;
        end else begin
            q <= d;
        end
    end

endmodule

//--- design/operandUse.sv
`timescale 1ns/1ps

module operandUse (
    input  logic [31:0]      inst,
    output ctrlPkg::regUse_t regUse
);

    ctrlPkg::opcode_e op;

    assign op = ctrlPkg::opcode_e'(inst[6:2]);

    // register indices are taken straight from the fixed RV32I fields
    assign regUse.rs1 = inst[19:15];
    assign regUse.rs2 = inst[24:20];
    assign regUse.rd  = inst[11:7];

    assign regUse.isCsrw = op == ctrlPkg::OP_CSRW;

    // upper immediates, JAL and the markers carry no rs1
    assign regUse.readsRs1 = !(op inside {
        ctrlPkg::OP_LUI,
        ctrlPkg::OP_AUIPC,
        ctrlPkg::OP_JAL,
        ctrlPkg::OP_X,
        ctrlPkg::OP_RST
    });

    assign regUse.readsRs2 = op inside {
        ctrlPkg::OP_R,
        ctrlPkg::OP_STORE,
        ctrlPkg::OP_BRANCH
    };

    // CSRW writes the CSR file, not the register file
    assign regUse.writesRd = !(op inside {
        ctrlPkg::OP_BRANCH,
        ctrlPkg::OP_STORE,
        ctrlPkg::OP_CSRW,
        ctrlPkg::OP_X,
        ctrlPkg::OP_RST
    });

endmodule

//--- design/exControl.sv
`timescale 1ns/1ps
`include "ctrl_settings.svh"

module exControl (
    input  logic [31:0]      inst,
    input  logic             brEq,
    input  logic             brLt,
    input  logic [31:0]      aluOut,
    output ctrlPkg::exCtrl_t ctrl,
    output logic             txValid,
    output logic             rxReady
);

    ctrlPkg::opcode_e op;
    logic [2:0]       funct3;
    logic             isLoad;
    logic             isStore;
    logic             uartHit;
    logic [2:0]       mmapSel;

    assign op      = ctrlPkg::opcode_e'(inst[6:2]);
    assign funct3  = inst[14:12];
    assign isLoad  = op == ctrlPkg::OP_LOAD;
    assign isStore = op == ctrlPkg::OP_STORE;

    assign uartHit = aluOut inside {
        `UART_CTRL, `UART_RX, `UART_TX, `UART_CC, `UART_IC, `UART_RST
    };

    // one strobe per access, the pipeline never stalls
    assign txValid = isStore && (aluOut == `UART_TX);
    assign rxReady = isLoad && (aluOut == `UART_RX);

    // memory map select, 6 marks a control transfer
    always_comb begin
        case (aluOut)
            `UART_CTRL: mmapSel = isLoad ? 3'd0 : 3'd7;
            `UART_RX:   mmapSel = isLoad ? 3'd1 : 3'd7;
            `UART_TX:   mmapSel = isStore ? 3'd2 : 3'd7;
            `UART_CC:   mmapSel = isLoad ? 3'd3 : 3'd7;
            `UART_IC:   mmapSel = isLoad ? 3'd4 : 3'd7;
            `UART_RST:  mmapSel = isStore ? 3'd5 : 3'd7;
            default: begin
                mmapSel = (op == ctrlPkg::OP_BRANCH || op == ctrlPkg::OP_JAL) ? 3'd6 : 3'd7;
            end
        endcase
    end

    always_comb begin
        // register-immediate add is the common case
        ctrl.aSel    = 1'b0;
        ctrl.bSel    = 1'b1;
        ctrl.aluSel  = ctrlPkg::ALU_ADD;
        ctrl.pcSel   = 2'd0;
        ctrl.instSel = 1'b0;
        ctrl.sSel    = 2'd3;
        ctrl.csrEn   = 1'b0;
        ctrl.csrSel  = 1'b0;
        ctrl.brUn    = 1'b0;
        ctrl.memRW   = (isLoad || isStore) && !uartHit;
        ctrl.mmapSel = mmapSel;

        case (op)
            ctrlPkg::OP_LOAD: ;
            ctrlPkg::OP_STORE: ctrl.sSel = funct3[1:0];
            ctrlPkg::OP_BRANCH: begin
                ctrl.aSel    = 1'b1;
                ctrl.instSel = 1'b1;
                // BLTU and BGEU compare unsigned
                ctrl.brUn    = funct3[2:1] == 2'b11;
                case (funct3)
                    3'd0:       ctrl.pcSel = brEq ? 2'd1 : 2'd2;
                    3'd1:       ctrl.pcSel = brEq ? 2'd2 : 2'd1;
                    3'd4, 3'd6: ctrl.pcSel = brLt ? 2'd1 : 2'd2;
                    3'd5, 3'd7: ctrl.pcSel = brLt ? 2'd2 : 2'd1;
                    default:    ctrl.pcSel = 2'd0;
                endcase
            end
            ctrlPkg::OP_JALR: begin
                ctrl.instSel = 1'b1;
                ctrl.pcSel   = 2'd1;
            end
            ctrlPkg::OP_JAL: begin
                ctrl.aSel    = 1'b1;
                ctrl.instSel = 1'b1;
                ctrl.pcSel   = 2'd1;
            end
            ctrlPkg::OP_R: begin
                ctrl.bSel   = 1'b0;
                ctrl.aluSel = ctrlPkg::aluOp_e'({inst[30], funct3});
            end
            ctrlPkg::OP_I: begin
                // funct7[5] only matters for the shifts
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    ctrl.aluSel = ctrlPkg::aluOp_e'({inst[30], funct3});
                end else begin
                    ctrl.aluSel = ctrlPkg::aluOp_e'({1'b0, funct3});
                end
            end
            ctrlPkg::OP_AUIPC: ctrl.aSel = 1'b1;
            ctrlPkg::OP_LUI: ctrl.aluSel = ctrlPkg::ALU_PASSB;
            ctrlPkg::OP_CSRW: begin
                ctrl.bSel   = 1'b0;
                ctrl.aluSel = ctrlPkg::ALU_PASSB;
                ctrl.csrEn  = 1'b1;
                ctrl.csrSel = funct3[2];
            end
            ctrlPkg::OP_RST: begin
                // boot source while the reset marker is in execute
                ctrl.aluSel  = ctrlPkg::ALU_PASSB;
                ctrl.instSel = 1'b1;
                ctrl.pcSel   = 2'd2;
            end
            default: begin
                ctrl.aluSel  = ctrlPkg::ALU_PASSB;
                ctrl.instSel = 1'b1;
            end
        endcase
    end

endmodule

//--- design/wbControl.sv
`timescale 1ns/1ps
`include "ctrl_settings.svh"

module wbControl (
    input  logic [31:0]      inst,
    input  logic [31:0]      aluAddr,
    output ctrlPkg::wbCtrl_t ctrl,
    output logic             writesRd
);

    ctrlPkg::opcode_e op;
    logic             dmemHit;
    logic             uartRd;

    assign op = ctrlPkg::opcode_e'(inst[6:2]);

    // destination rule used by forwarding, independent of the load address
    assign writesRd = !(op inside {
        ctrlPkg::OP_BRANCH,
        ctrlPkg::OP_STORE,
        ctrlPkg::OP_CSRW,
        ctrlPkg::OP_X,
        ctrlPkg::OP_RST
    });

    assign dmemHit = aluAddr[31:28] inside {`DMEM_REGIONS};

    // UART registers a load may read, RX has its own path
    assign uartRd = aluAddr inside {`UART_CTRL, `UART_CC, `UART_IC};

    always_comb begin
        ctrl.ldSel       = 3'd7;
        ctrl.wbSel       = 2'd0;
        ctrl.regWrEn     = 1'b0;
        ctrl.mmapDmemSel = 2'd0;

        case (op)
            ctrlPkg::OP_LOAD: begin
                ctrl.ldSel   = inst[14:12];
                ctrl.wbSel   = 2'd0;
                ctrl.regWrEn = dmemHit || uartRd || (aluAddr == `UART_RX);
                if (aluAddr == `UART_RX) begin
                    ctrl.mmapDmemSel = 2'd1;
                end else if (uartRd) begin
                    ctrl.mmapDmemSel = 2'd2;
                end
            end
            ctrlPkg::OP_JAL, ctrlPkg::OP_JALR: begin
                // link register gets PC + 4
                ctrl.wbSel   = 2'd2;
                ctrl.regWrEn = 1'b1;
            end
            ctrlPkg::OP_R, ctrlPkg::OP_I, ctrlPkg::OP_AUIPC, ctrlPkg::OP_LUI: begin
                ctrl.wbSel   = 2'd1;
                ctrl.regWrEn = 1'b1;
            end
            // stores, branches, CSRW and the markers write nothing
            default: ;
        endcase
    end

endmodule

//--- design/forwardUnit.sv
`timescale 1ns/1ps

module forwardUnit (
    input  ctrlPkg::regUse_t decUse,
    input  ctrlPkg::regUse_t exUse,
    input  logic [4:0]       wbRd,
    input  logic             wbWrites,
    output ctrlPkg::fwd_t    fwd
);

    // one rule for every path
    // x0 only matches for a CSRW reading its rs1
    function automatic logic pathHit(
        input logic       reads,
        input logic [4:0] idx,
        input logic       x0Ok
    );
        logic sameReg;
        logic nonZero;
        sameReg = idx == wbRd;
        nonZero = (idx != 5'd0) && (wbRd != 5'd0);
        return wbWrites && reads && sameReg && (nonZero || x0Ok);
    endfunction

    // decode stage readers
    assign fwd.fa1 = pathHit(decUse.readsRs1, decUse.rs1, decUse.isCsrw);
    assign fwd.fb1 = pathHit(decUse.readsRs2, decUse.rs2, 1'b0);

    // execute stage readers
    assign fwd.fa2 = pathHit(exUse.readsRs1, exUse.rs1, exUse.isCsrw);
    assign fwd.fb2 = pathHit(exUse.readsRs2, exUse.rs2, 1'b0);

endmodule

//--- design/pipeCtrl.sv
`timescale 1ns/1ps
`include "ctrl_settings.svh"

module pipeCtrl (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       inst,
    input  logic              brEq,
    input  logic              brLt,
    input  logic [31:0]       aluOut,
    output ctrlPkg::immFmt_e  immSel,
    output ctrlPkg::exCtrl_t  exCtrl,
    output ctrlPkg::wbCtrl_t  wbCtrl,
    output ctrlPkg::fwd_t     fwd,
    output logic              txValid,
    output logic              rxReady
);

    logic [31:0]      exInst;
    logic [31:0]      wbInst;
    logic [31:0]      wbAlu;
    logic             wbWrites;
    ctrlPkg::regUse_t decUse;
    ctrlPkg::regUse_t exUse;

    // instruction pipe resets to the reset marker
    stageReg #(.T(logic [31:0]), .RESET_VAL(`RESET_PC + 32'd4)) exInstReg (
        .clk(clk), .rst(rst), .d(inst), .q(exInst)
    );

    stageReg #(.T(logic [31:0]), .RESET_VAL(`RESET_PC + 32'd4)) wbInstReg (
        .clk(clk), .rst(rst), .d(exInst), .q(wbInst)
    );

    // load address for the writeback decision
    stageReg #(.T(logic [31:0]), .RESET_VAL(32'd0)) wbAluReg (
        .clk(clk), .rst(rst), .d(aluOut), .q(wbAlu)
    );

    operandUse decOperands (.inst(inst), .regUse(decUse));
    operandUse exOperands (.inst(exInst), .regUse(exUse));

    // immediate format of the instruction in decode
    always_comb begin
        case (ctrlPkg::opcode_e'(inst[6:2]))
            ctrlPkg::OP_LOAD, ctrlPkg::OP_JALR, ctrlPkg::OP_I: immSel = ctrlPkg::IMM_I;
            ctrlPkg::OP_STORE:                  immSel = ctrlPkg::IMM_S;
            ctrlPkg::OP_BRANCH:                 immSel = ctrlPkg::IMM_B;
            ctrlPkg::OP_JAL:                    immSel = ctrlPkg::IMM_J;
            ctrlPkg::OP_AUIPC, ctrlPkg::OP_LUI: immSel = ctrlPkg::IMM_U;
            default:                            immSel = ctrlPkg::IMM_NONE;
        endcase
    end

    exControl exCtl (
        .inst(exInst), .brEq(brEq), .brLt(brLt), .aluOut(aluOut),
        .ctrl(exCtrl), .txValid(txValid), .rxReady(rxReady)
    );

    wbControl wbCtl (
        .inst(wbInst), .aluAddr(wbAlu), .ctrl(wbCtrl), .writesRd(wbWrites)
    );

    forwardUnit fwdUnit (
        .decUse(decUse), .exUse(exUse), .wbRd(wbInst[11:7]),
        .wbWrites(wbWrites), .fwd(fwd)
    );

endmodule

//--- tb/pipeCtrl_assert.sv
`timescale 1ns/1ps

module pipeCtrl_assert (
    input logic clk,
    input logic rst,
    input logic txValid,
    input logic rxReady,
    input logic memRW
);

    // reset seen on the previous edge, so the first reset edge is skipped
    logic rstHeld = 1'b0;

    always @(posedge clk) begin
        rstHeld <= rst;
    end

    strobesExclusive: assert property (@(posedge clk) disable iff (rst)
        !(txValid && rxReady))
        else $error("txValid and rxReady are high in the same cycle");

    quietAfterReset: assert property (@(posedge clk)
        $fell(rst) |-> !txValid && !rxReady)
        else $error("a UART strobe fired in the first cycle after reset");

    quietInReset: assert property (@(posedge clk)
        rst && rstHeld |-> !txValid && !rxReady && !memRW)
        else $error("a side effect is active while reset is held");

    // UART accesses never touch data memory
    memApartFromStrobe: assert property (@(posedge clk) disable iff (rst)
        $rose(memRW) |-> !txValid && !rxReady)
        else $error("memRW rose together with a UART strobe");

endmodule

bind pipeCtrl pipeCtrl_assert strobeChecks (
    .clk(clk), .rst(rst), .txValid(txValid), .rxReady(rxReady), .memRW(exCtrl.memRW)
);

//--- tb/pipeCtrl_tb.sv
`timescale 1ns/1ps
`include "ctrl_settings.svh"

module pipeCtrl_tb;

    localparam int NUM_INSTS  = 3000;
    localparam int MAX_CYCLES = NUM_INSTS + 50;

    localparam logic [31:0] UART_MAP [6] = '{
        `UART_CTRL, `UART_RX, `UART_TX, `UART_CC, `UART_IC, `UART_RST
    };
    localparam logic [3:0] REGIONS [3] = '{`DMEM_REGIONS};
    localparam logic [4:0] OPS [12] = '{
        ctrlPkg::OP_LOAD, ctrlPkg::OP_STORE, ctrlPkg::OP_BRANCH, ctrlPkg::OP_JALR,
        ctrlPkg::OP_JAL, ctrlPkg::OP_R, ctrlPkg::OP_I, ctrlPkg::OP_AUIPC,
        ctrlPkg::OP_LUI, ctrlPkg::OP_CSRW, ctrlPkg::OP_X, ctrlPkg::OP_RST
    };

    logic             clk;
    logic             rst;
    logic [31:0]      inst;
    logic             brEq;
    logic             brLt;
    logic [31:0]      aluOut;
    ctrlPkg::immFmt_e immSel;
    ctrlPkg::exCtrl_t exCtrl;
    ctrlPkg::wbCtrl_t wbCtrl;
    ctrlPkg::fwd_t    fwd;
    logic             txValid;
    logic             rxReady;

    int errorCount = 0;
    int checkCount = 0;
    int cycles     = 0;

    pipeCtrl UUT (
        .clk(clk), .rst(rst), .inst(inst), .brEq(brEq), .brLt(brLt), .aluOut(aluOut),
        .immSel(immSel), .exCtrl(exCtrl), .wbCtrl(wbCtrl), .fwd(fwd),
        .txValid(txValid), .rxReady(rxReady)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic checkVal(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("[FAIL] %s (cycle %0d): expected %0h, actual %0h",
                     name, cycles, expected, actual);
        end
    endtask

    // regWrEn, memRW, csrEn and both strobes must all be low
    task automatic checkQuiet(input string name);
        checkVal(name, 32'd0,
                 32'({wbCtrl.regWrEn, exCtrl.memRW, exCtrl.csrEn, txValid, rxReady}));
    endtask

    function automatic logic usesRs1(input logic [4:0] op);
        return !(op inside {ctrlPkg::OP_LUI, ctrlPkg::OP_AUIPC, ctrlPkg::OP_JAL,
                            ctrlPkg::OP_X, ctrlPkg::OP_RST});
    endfunction

    function automatic logic usesRs2(input logic [4:0] op);
        return op inside {ctrlPkg::OP_R, ctrlPkg::OP_STORE, ctrlPkg::OP_BRANCH};
    endfunction

    function automatic logic writesReg(input logic [4:0] op);
        return !(op inside {ctrlPkg::OP_BRANCH, ctrlPkg::OP_STORE, ctrlPkg::OP_CSRW,
                            ctrlPkg::OP_X, ctrlPkg::OP_RST});
    endfunction

    function automatic int uartIndex(input logic [31:0] a);
        int idx;
        idx = -1;
        for (int i = 0; i < 6; i++) begin
            if (a == UART_MAP[3'(i)]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic logic [2:0] immFormat(input logic [4:0] op);
        case (op)
            ctrlPkg::OP_LOAD, ctrlPkg::OP_JALR, ctrlPkg::OP_I: return ctrlPkg::IMM_I;
            ctrlPkg::OP_STORE:                  return ctrlPkg::IMM_S;
            ctrlPkg::OP_BRANCH:                 return ctrlPkg::IMM_B;
            ctrlPkg::OP_JAL:                    return ctrlPkg::IMM_J;
            ctrlPkg::OP_AUIPC, ctrlPkg::OP_LUI: return ctrlPkg::IMM_U;
            default:                            return ctrlPkg::IMM_NONE;
        endcase
    endfunction

    function automatic ctrlPkg::exCtrl_t predictEx(input logic [31:0] w, input logic [31:0] a,
                                                   input logic eq, input logic lt);
        ctrlPkg::exCtrl_t c;
        logic [4:0] op;
        logic [2:0] f3;
        logic isLoad;
        logic isStore;
        logic taken;
        int idx;
        op = w[6:2];
        f3 = w[14:12];
        isLoad = op == ctrlPkg::OP_LOAD;
        isStore = op == ctrlPkg::OP_STORE;
        idx = uartIndex(a);
        c = '0;
        c.bSel = 1'b1;
        c.sSel = 2'd3;
        c.aluSel = ctrlPkg::ALU_ADD;
        c.memRW = (isLoad || isStore) && idx < 0;
        // TX and RST are written and the other UART registers are read
        if (idx < 0) begin
            c.mmapSel = (op == ctrlPkg::OP_BRANCH || op == ctrlPkg::OP_JAL) ? 3'd6 : 3'd7;
        end else if ((idx == 2 || idx == 5) ? isStore : isLoad) begin
            c.mmapSel = 3'(idx);
        end else begin
            c.mmapSel = 3'd7;
        end
        case (op)
            ctrlPkg::OP_STORE: c.sSel = f3[1:0];
            ctrlPkg::OP_BRANCH: begin
                c.aSel = 1'b1;
                c.instSel = 1'b1;
                c.brUn = f3[2:1] == 2'b11;
                // funct3 bit 0 inverts the condition and bit 2 picks less-than
                taken = f3[2] ? (lt ^ f3[0]) : (eq ^ f3[0]);
                c.pcSel = (f3[2:1] == 2'b01) ? 2'd0 : (taken ? 2'd1 : 2'd2);
            end
            ctrlPkg::OP_JALR: begin
                c.instSel = 1'b1;
                c.pcSel = 2'd1;
            end
            ctrlPkg::OP_JAL: begin
                c.aSel = 1'b1;
                c.instSel = 1'b1;
                c.pcSel = 2'd1;
            end
            ctrlPkg::OP_R: begin
                c.bSel = 1'b0;
                c.aluSel = ctrlPkg::aluOp_e'({w[30], f3});
            end
            ctrlPkg::OP_I: c.aluSel = ctrlPkg::aluOp_e'({w[30] & (f3[1:0] == 2'b01), f3});
            ctrlPkg::OP_AUIPC: c.aSel = 1'b1;
            ctrlPkg::OP_LUI: c.aluSel = ctrlPkg::ALU_PASSB;
            ctrlPkg::OP_CSRW: begin
                c.bSel = 1'b0;
                c.aluSel = ctrlPkg::ALU_PASSB;
                c.csrEn = 1'b1;
                c.csrSel = f3[2];
            end
            ctrlPkg::OP_RST: begin
                c.aluSel = ctrlPkg::ALU_PASSB;
                c.instSel = 1'b1;
                c.pcSel = 2'd2;
            end
            ctrlPkg::OP_X: begin
                c.aluSel = ctrlPkg::ALU_PASSB;
                c.instSel = 1'b1;
            end
            default: ;
        endcase
        return c;
    endfunction

    function automatic ctrlPkg::wbCtrl_t wbExpected(input logic [31:0] w, input logic [31:0] a);
        ctrlPkg::wbCtrl_t c;
        logic uartRead;
        int idx;
        idx = uartIndex(a);
        uartRead = idx == 0 || idx == 3 || idx == 4;
        c = '0;
        c.ldSel = 3'd7;
        case (w[6:2])
            ctrlPkg::OP_LOAD: begin
                c.ldSel = w[14:12];
                c.regWrEn = a[31:28] inside {`DMEM_REGIONS} || uartRead || idx == 1;
                c.mmapDmemSel = (idx == 1) ? 2'd1 : (uartRead ? 2'd2 : 2'd0);
            end
            ctrlPkg::OP_JAL, ctrlPkg::OP_JALR: begin
                c.wbSel = 2'd2;
                c.regWrEn = 1'b1;
            end
            ctrlPkg::OP_R, ctrlPkg::OP_I, ctrlPkg::OP_AUIPC, ctrlPkg::OP_LUI: begin
                c.wbSel = 2'd1;
                c.regWrEn = 1'b1;
            end
            default: ;
        endcase
        return c;
    endfunction

    function automatic logic fwdHit(input logic reads, input logic [4:0] idx,
                                    input logic csrRs1, input logic [31:0] wb);
        logic [4:0] wbRd;
        wbRd = wb[11:7];
        return writesReg(wb[6:2]) && reads && idx == wbRd &&
               ((idx != 5'd0 && wbRd != 5'd0) || csrRs1);
    endfunction

    function automatic ctrlPkg::fwd_t forwardFlags(input logic [31:0] dec, input logic [31:0] ex,
                                                   input logic [31:0] wb);
        ctrlPkg::fwd_t f;
        f.fa1 = fwdHit(usesRs1(dec[6:2]), dec[19:15], dec[6:2] == ctrlPkg::OP_CSRW, wb);
        f.fb1 = fwdHit(usesRs2(dec[6:2]), dec[24:20], 1'b0, wb);
        f.fa2 = fwdHit(usesRs1(ex[6:2]), ex[19:15], ex[6:2] == ctrlPkg::OP_CSRW, wb);
        f.fb2 = fwdHit(usesRs2(ex[6:2]), ex[24:20], 1'b0, wb);
        return f;
    endfunction

    // register indices stay in x0..x3 so that forwarding matches are frequent
    function automatic logic [31:0] randInst();
        logic [4:0] op;
        op = OPS[4'($urandom_range(0, 11))];
        return {7'($urandom), 5'($urandom_range(0, 3)), 5'($urandom_range(0, 3)),
                3'($urandom), 5'($urandom_range(0, 3)), op, 2'b11};
    endfunction

    function automatic logic [31:0] randAddr();
        int kind;
        kind = $urandom_range(0, 9);
        if (kind < 4) begin
            return UART_MAP[3'($urandom_range(0, 5))];
        end
        if (kind < 7) begin
            return {REGIONS[2'($urandom_range(0, 2))], 28'($urandom)};
        end
        return $urandom;
    endfunction

    initial begin
        logic [31:0] prevInst;
        logic [31:0] olderInst;
        logic [31:0] prevAlu;
        void'($urandom(32'h675e7dca));
        rst = 1'b1;
        inst = 32'd0;
        brEq = 1'b0;
        brLt = 1'b0;
        aluOut = 32'd0;
        // both instruction stages start out holding the reset marker
        prevInst = `RESET_PC + 32'd4;
        olderInst = `RESET_PC + 32'd4;
        prevAlu = 32'd0;
        // live traffic during reset, so a missing reset shows up
        repeat (5) begin
            @(negedge clk);
            checkQuiet("reset");
            inst = randInst();
            aluOut = randAddr();
        end
        rst = 1'b0;
        for (int n = 0; n < NUM_INSTS; n++) begin
            inst = randInst();
            aluOut = randAddr();
            brEq = 1'($urandom);
            brLt = 1'($urandom);
            #2;
            if (n == 0) begin
                checkQuiet("after reset");
            end
            checkVal("immSel", 32'(immFormat(inst[6:2])), 32'(immSel));
            checkVal("exCtrl", 32'(predictEx(prevInst, aluOut, brEq, brLt)), 32'(exCtrl));
            checkVal("wbCtrl", 32'(wbExpected(olderInst, prevAlu)), 32'(wbCtrl));
            checkVal("fwd", 32'(forwardFlags(inst, prevInst, olderInst)), 32'(fwd));
            checkVal("txValid", 32'(prevInst[6:2] == ctrlPkg::OP_STORE && aluOut == `UART_TX),
                     32'(txValid));
            checkVal("rxReady", 32'(prevInst[6:2] == ctrlPkg::OP_LOAD && aluOut == `UART_RX),
                     32'(rxReady));
            olderInst = prevInst;
            prevInst = inst;
            prevAlu = aluOut;
            @(negedge clk);
        end
        $display("checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+design
design/ctrlPkg.sv
design/stageReg.sv
design/operandUse.sv
design/exControl.sv
design/wbControl.sv
design/forwardUnit.sv
design/pipeCtrl.sv
tb/pipeCtrl_assert.sv
tb/pipeCtrl_tb.sv

//--- Makefile
# Verilator build and run of the pipeline control testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module pipeCtrl_tb -f compile.f --Mdir obj_dir -o simv

run: compile
	./obj_dir/simv > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Some tests failed" sim.log; then exit 1; fi
	@grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
